/* sim.f */
verilog/rv_pkg.sv
verilog/ctrl_if.sv
verilog/function_unit.sv
verilog/regfile.sv
verilog/data_mem.sv
verilog/datapath.sv
verilog/pc_counter.sv
verilog/control_fsm.sv
verilog/cpu_core.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/tb_cpu_core.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log for the fail message

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary -f sim.f --top-module tb_cpu_core -o tb_cpu_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_cpu_core_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$log"; then
    exit 1
fi
exit 0

/* verification/tb_cpu_core.sv */
// testbench top with instruction table, falling-edge handshake driver and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;
    import rv_pkg::*;

    localparam int reset_cycles = 8;
    localparam int ack_limit    = 8;

    localparam int op_load   = 'h03;
    localparam int op_imm    = 'h13;
    localparam int op_auipc  = 'h17;
    localparam int op_lui    = 'h37;
    localparam int op_jalr   = 'h67;
    localparam int op_system = 'h73;

    logic         clk;
    logic         reset;
    logic         instr_req;
    word_t        instr;
    logic         instr_ack;
    word_t        pc;
    logic         retire_we;
    reg_addr_t    retire_rd;
    word_t        retire_value;
    logic [127:0] exp_name;
    logic         exp_we;
    reg_addr_t    exp_rd;
    word_t        exp_value;
    word_t        exp_pc;
    int           error_count;
    int           commit_count;
    int           tb_errors   = 0;
    logic         table_ready = 1'b0;

    // one entry per row
    logic [127:0] t_name[$];
    word_t        t_instr[$];
    logic         t_we[$];
    reg_addr_t    t_rd[$];
    word_t        t_value[$];
    word_t        t_pc[$];
    int           t_hold[$];

    tb_clock_gen #(.period_ns(20)) clkgen (.clk(clk));

    cpu_core #(.mem_words(128)) dut0 (
        .clk          (clk),
        .reset        (reset),
        .instr_req    (instr_req),
        .instr        (instr),
        .instr_ack    (instr_ack),
        .pc           (pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_value (retire_value)
    );

    tb_checker chk (
        .clk          (clk),
        .reset        (reset),
        .instr_req    (instr_req),
        .instr_ack    (instr_ack),
        .pc           (pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_value (retire_value),
        .exp_name     (exp_name),
        .exp_we       (exp_we),
        .exp_rd       (exp_rd),
        .exp_value    (exp_value),
        .exp_pc       (exp_pc),
        .error_count  (error_count),
        .commit_count (commit_count)
    );

    // rv32i instruction formats
    function automatic word_t r_type(input int f7, input int f3, input int rd,
                                     input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic word_t i_type(input int op, input int f3, input int rd,
                                     input int rs1, input int imm);
        word_t v;
        v = imm;
        return {v[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t s_type(input int f3, input int rs2, input int rs1, input int imm);
        word_t v;
        v = imm;
        return {v[11:5], rs2[4:0], rs1[4:0], f3[2:0], v[4:0], 7'h23};
    endfunction

    function automatic word_t b_type(input int f3, input int rs1, input int rs2, input int imm);
        word_t v;
        v = imm;
        return {v[12], v[10:5], rs2[4:0], rs1[4:0], f3[2:0], v[4:1], v[11], 7'h63};
    endfunction

    function automatic word_t u_type(input int op, input int rd, input int imm20);
        word_t v;
        v = imm20;
        return {v[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t j_type(input int rd, input int imm);
        word_t v;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic add_row(input logic [127:0] name, input word_t word, input int we,
                           input int rd, input word_t value, input word_t next_pc,
                           input int hold);
        t_name.push_back(name);
        t_instr.push_back(word);
        t_we.push_back(we != 0);
        t_rd.push_back(rd[4:0]);
        t_value.push_back(value);
        t_pc.push_back(next_pc);
        t_hold.push_back(hold);
    endtask

    // name, instruction, we, rd, value, next pc, extra hold cycles
    task automatic load_table();
        add_row("addi x1", i_type(op_imm, 0, 1, 0, 5), 1, 1, 32'h0000_0005, 32'h04, 0);
        add_row("addi x2", i_type(op_imm, 0, 2, 0, -3), 1, 2, 32'hffff_fffd, 32'h08, 0);
        add_row("add", r_type(0, 0, 3, 1, 2), 1, 3, 32'h0000_0002, 32'h0c, 0);
        add_row("sub", r_type('h20, 0, 4, 1, 2), 1, 4, 32'h0000_0008, 32'h10, 2);
        add_row("slt", r_type(0, 2, 5, 2, 1), 1, 5, 32'h0000_0001, 32'h14, 0);
        add_row("sltu", r_type(0, 3, 6, 2, 1), 1, 6, 32'h0000_0000, 32'h18, 0);
        add_row("xor", r_type(0, 4, 7, 1, 2), 1, 7, 32'hffff_fff8, 32'h1c, 0);
        add_row("or", r_type(0, 6, 8, 1, 2), 1, 8, 32'hffff_fffd, 32'h20, 0);
        add_row("and", r_type(0, 7, 9, 1, 2), 1, 9, 32'h0000_0005, 32'h24, 0);
        add_row("sll", r_type(0, 1, 10, 1, 1), 1, 10, 32'h0000_00a0, 32'h28, 0);
        add_row("srl", r_type(0, 5, 11, 2, 1), 1, 11, 32'h07ff_ffff, 32'h2c, 0);
        add_row("sra", r_type('h20, 5, 12, 2, 1), 1, 12, 32'hffff_ffff, 32'h30, 0);
        add_row("addi x0", i_type(op_imm, 0, 0, 1, 7), 1, 0, 32'h0000_000c, 32'h34, 0);
        add_row("add x0 read", r_type(0, 0, 13, 0, 1), 1, 13, 32'h0000_0005, 32'h38, 0);
        add_row("srai", i_type(op_imm, 5, 14, 2, 'h401), 1, 14, 32'hffff_fffe, 32'h3c, 0);
        add_row("lui", u_type(op_lui, 15, 'h12345), 1, 15, 32'h1234_5000, 32'h40, 0);
        add_row("auipc", u_type(op_auipc, 16, 1), 1, 16, 32'h0000_1040, 32'h44, 0);
        add_row("addi base", i_type(op_imm, 0, 17, 0, 'h100), 1, 17, 32'h0000_0100, 32'h48, 0);
        // word at 0x104 is built up by the stores below
        add_row("sw", s_type(2, 15, 17, 4), 0, 0, 32'h0, 32'h4c, 0);
        add_row("lw", i_type(op_load, 2, 18, 17, 4), 1, 18, 32'h1234_5000, 32'h50, 0);
        add_row("sh lane2", s_type(1, 2, 17, 6), 0, 0, 32'h0, 32'h54, 0);
        add_row("lh", i_type(op_load, 1, 19, 17, 6), 1, 19, 32'hffff_fffd, 32'h58, 0);
        add_row("lhu", i_type(op_load, 5, 20, 17, 6), 1, 20, 32'h0000_fffd, 32'h5c, 0);
        add_row("sb lane0", s_type(0, 7, 17, 4), 0, 0, 32'h0, 32'h60, 0);
        add_row("sb lane1", s_type(0, 1, 17, 5), 0, 0, 32'h0, 32'h64, 0);
        add_row("sb lane2", s_type(0, 11, 17, 6), 0, 0, 32'h0, 32'h68, 0);
        add_row("sb lane3", s_type(0, 15, 17, 7), 0, 0, 32'h0, 32'h6c, 0);
        add_row("lw bytes", i_type(op_load, 2, 22, 17, 4), 1, 22, 32'h00ff_05f8, 32'h70, 0);
        add_row("lb lane0", i_type(op_load, 0, 23, 17, 4), 1, 23, 32'hffff_fff8, 32'h74, 0);
        add_row("lbu lane0", i_type(op_load, 4, 24, 17, 4), 1, 24, 32'h0000_00f8, 32'h78, 0);
        add_row("lb lane2", i_type(op_load, 0, 25, 17, 6), 1, 25, 32'hffff_ffff, 32'h7c, 0);
        add_row("lbu lane1", i_type(op_load, 4, 26, 17, 5), 1, 26, 32'h0000_0005, 32'h80, 0);
        add_row("lb lane3", i_type(op_load, 0, 27, 17, 7), 1, 27, 32'h0000_0000, 32'h84, 0);
        // x1 = 5, x2 = -3, x3 = 2, x9 = 5
        add_row("beq taken", b_type(0, 1, 9, 16), 0, 0, 32'h0, 32'h94, 0);
        add_row("beq not taken", b_type(0, 1, 3, 16), 0, 0, 32'h0, 32'h98, 0);
        add_row("bne taken", b_type(1, 1, 3, 8), 0, 0, 32'h0, 32'ha0, 0);
        add_row("bne not taken", b_type(1, 1, 9, 8), 0, 0, 32'h0, 32'ha4, 0);
        add_row("blt taken", b_type(4, 2, 1, -12), 0, 0, 32'h0, 32'h98, 0);
        add_row("blt not taken", b_type(4, 1, 2, 8), 0, 0, 32'h0, 32'h9c, 0);
        add_row("bge taken", b_type(5, 1, 2, 20), 0, 0, 32'h0, 32'hb0, 0);
        add_row("bge not taken", b_type(5, 2, 1, 8), 0, 0, 32'h0, 32'hb4, 0);
        add_row("bltu taken", b_type(6, 1, 2, 8), 0, 0, 32'h0, 32'hbc, 0);
        add_row("bltu not taken", b_type(6, 2, 1, 8), 0, 0, 32'h0, 32'hc0, 0);
        add_row("bgeu taken", b_type(7, 2, 1, 12), 0, 0, 32'h0, 32'hcc, 0);
        add_row("bgeu not taken", b_type(7, 1, 2, 8), 0, 0, 32'h0, 32'hd0, 0);
        add_row("jal", j_type(28, 40), 1, 28, 32'h0000_00d4, 32'hf8, 0);
        add_row("jalr", i_type(op_jalr, 0, 29, 17, 33), 1, 29, 32'h0000_00fc, 32'h120, 0);
        add_row("csrrw no-op", i_type(op_system, 1, 5, 1, 'h300), 0, 0, 32'h0, 32'h124, 0);
        add_row("unknown opcode", 32'hffff_ffff, 0, 0, 32'h0, 32'h128, 3);
        add_row("csr rd kept", r_type(0, 0, 30, 5, 0), 1, 30, 32'h0000_0001, 32'h12c, 0);
        add_row("jalr to x0", i_type(op_jalr, 0, 0, 28, 0), 1, 0, 32'h0000_0130, 32'hd4, 0);
        add_row("addi x31", i_type(op_imm, 0, 31, 0, -1), 1, 31, 32'hffff_ffff, 32'hd8, 0);
    endtask

    // one full four-phase handshake, inputs change on falling edges
    task automatic apply_row(input int i);
        int waited;
        @(negedge clk);
        instr     = t_instr[i];
        exp_name  = t_name[i];
        exp_we    = t_we[i];
        exp_rd    = t_rd[i];
        exp_value = t_value[i];
        exp_pc    = t_pc[i];
        instr_req = 1'b1;
        waited    = 0;
        while (instr_ack !== 1'b1 && waited < ack_limit) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (instr_ack !== 1'b1) begin
            $display("no acknowledge from the core for %s", t_name[i]);
            tb_errors = tb_errors + 1;
        end
        // back-pressure, keep the request up a little longer
        repeat (t_hold[i]) @(negedge clk);
        instr_req = 1'b0;
        waited    = 0;
        while (instr_ack !== 1'b0 && waited < ack_limit) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (instr_ack !== 1'b0) begin
            $display("instr_ack stayed high after the request for %s was dropped", t_name[i]);
            tb_errors = tb_errors + 1;
        end
    endtask

    initial begin
        int total;
        reset     = 1'b1;
        instr_req = 1'b0;
        instr     = '0;
        exp_name  = "reset";
        exp_we    = 1'b0;
        exp_rd    = '0;
        exp_value = '0;
        exp_pc    = '0;
        load_table();
        table_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < t_name.size(); i++) begin
            apply_row(i);
        end
        repeat (2) @(negedge clk);
        if (commit_count != t_name.size()) begin
            $display("checker saw %0d commits for %0d table rows", commit_count, t_name.size());
            tb_errors = tb_errors + 1;
        end
        total = error_count + tb_errors;
        $display("errors: %0d", total);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // about ten cycles per row plus the reset time
    initial begin
        wait (table_ready);
        repeat (t_name.size() * 10 + reset_cycles) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles",
                 t_name.size() * 10 + reset_cycles);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/tb_checker.sv */
// handshake timing model and retire/pc comparison against the expected row
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_req,
    input  logic              instr_ack,
    input  rv_pkg::word_t     pc,
    input  logic              retire_we,
    input  rv_pkg::reg_addr_t retire_rd,
    input  rv_pkg::word_t     retire_value,
    input  logic [127:0]      exp_name,
    input  logic              exp_we,
    input  rv_pkg::reg_addr_t exp_rd,
    input  rv_pkg::word_t     exp_value,
    input  rv_pkg::word_t     exp_pc,
    output int                error_count,
    output int                commit_count
);
    import rv_pkg::*;

    int   value_errors     = 0;
    int   handshake_errors = 0;
    int   commits          = 0;
    int   edges            = 0;
    logic active           = 1'b0;
    logic exp_ack          = 1'b0;

    assign error_count  = value_errors + handshake_errors;
    assign commit_count = commits;

    task automatic compare_word(input string field, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected 0x%08h, actual 0x%08h",
                     exp_name, field, expected, actual);
            value_errors = value_errors + 1;
        end
    endtask

    // edge count since the request was sampled in idle
    always @(posedge clk) begin
        if (reset) begin
            active = 1'b0;
            edges  = 0;
        end else if (!active) begin
            if (instr_req) begin
                active = 1'b1;
                edges  = 1;
            end
        end else begin
            edges = edges + 1;
            // release edge returns the core to idle
            if (edges >= 4 && !instr_req) begin
                active = 1'b0;
                edges  = 0;
            end
        end
        exp_ack = active && (edges >= 3);
    end

    // ack checked away from the rising edge
    always @(negedge clk) begin
        if (!reset && instr_ack !== exp_ack) begin
            handshake_errors = handshake_errors + 1;
            if (exp_ack) begin
                $display("handshake fault: instr_ack is low at edge %0d of the request for %s",
                         edges, exp_name);
            end else begin
                $display("handshake fault: instr_ack is high while no acknowledge is due (%s)",
                         exp_name);
            end
        end
    end

    // retire outputs and pc are stable from the ack edge
    always @(posedge instr_ack) begin
        if (!reset) begin
            commits = commits + 1;
            compare_word("retire_we", {31'd0, exp_we}, {31'd0, retire_we});
            if (exp_we) begin
                compare_word("retire_rd", {27'd0, exp_rd}, {27'd0, retire_rd});
                compare_word("retire_value", exp_value, retire_value);
            end
            compare_word("pc", exp_pc, pc);
        end
    end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
// free-running testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns = 20
) (
    output logic clk
);

    logic clk_q = 1'b0;

    // half period high, half period low
    always #(period_ns / 2) clk_q = ~clk_q;

    assign clk = clk_q;

endmodule

`default_nettype wire

/* verilog/cpu_core.sv */
// single-issue rv32i core top level with req/ack instruction port
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
    parameter int mem_words = 128
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_req,
    input  rv_pkg::word_t     instr,
    output logic              instr_ack,
    output rv_pkg::word_t     pc,
    output logic              retire_we,
    output rv_pkg::reg_addr_t retire_rd,
    output rv_pkg::word_t     retire_value
);
    import rv_pkg::*;

    word_t  rs1_value;
    flags_t flags;

    ctrl_if cw ();

    control_fsm ctrl (
        .clk       (clk),
        .reset     (reset),
        .instr_req (instr_req),
        .instr     (instr),
        .instr_ack (instr_ack),
        .cw        (cw.ctrl)
    );

    // jalr target and branch decision live here
    pc_counter pcc (
        .clk       (clk),
        .reset     (reset),
        .cw        (cw.sink),
        .rs1_value (rs1_value),
        .flags     (flags),
        .pc        (pc)
    );

    datapath #(.mem_words(mem_words)) dp (
        .clk          (clk),
        .reset        (reset),
        .cw           (cw.sink),
        .pc           (pc),
        .rs1_value    (rs1_value),
        .flags        (flags),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_value (retire_value)
    );

endmodule

`default_nettype wire

/* verilog/control_fsm.sv */
// handshake FSM with instruction latch and rv32i decoder
`timescale 1ns/1ps
`default_nettype none

module control_fsm (
    input  logic          clk,
    input  logic          reset,
    input  logic          instr_req,
    input  rv_pkg::word_t instr,
    output logic          instr_ack,
    ctrl_if.ctrl          cw
);
    import rv_pkg::*;

    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_jal    = 7'b1101111;

    ctrl_state_t state;
    word_t       instr_q;
    logic [6:0]  opcode;
    word_t       imm_i;
    word_t       imm_s;
    word_t       imm_b;
    word_t       imm_u;
    word_t       imm_j;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    state <= instr_req ? st_exec : st_idle;
                st_exec:    state <= st_ack;
                st_ack:     state <= st_release;
                // wait for the requester to let go
                st_release: state <= instr_req ? st_release : st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    // capture the word on acceptance
    always_ff @(posedge clk) begin
        if (state == st_idle && instr_req) begin
            instr_q <= instr;
        end
    end

    assign instr_ack = (state == st_release);
    assign cw.step   = (state == st_exec);

    assign opcode    = instr_q[6:0];
    assign cw.rd     = instr_q[11:7];
    assign cw.funct3 = instr_q[14:12];
    assign cw.rs1    = instr_q[19:15];
    assign cw.rs2    = instr_q[24:20];
    assign cw.funct7 = instr_q[30];

    // immediate formats
    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                    instr_q[11:8], 1'b0};
    assign imm_u = {instr_q[31:12], 12'd0};
    assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                    instr_q[30:21], 1'b0};

    always_comb begin
        cw.imm = imm_i;
        case (opcode)
            op_load:   cw.kind = k_load;
            op_imm:    cw.kind = k_imm;
            op_jalr:   cw.kind = k_jalr;
            op_reg:    cw.kind = k_reg;
            op_store: begin
                cw.kind = k_store;
                cw.imm  = imm_s;
            end
            op_branch: begin
                cw.kind = k_branch;
                cw.imm  = imm_b;
            end
            op_lui: begin
                cw.kind = k_lui;
                cw.imm  = imm_u;
            end
            op_auipc: begin
                cw.kind = k_auipc;
                cw.imm  = imm_u;
            end
            op_jal: begin
                cw.kind = k_jal;
                cw.imm  = imm_j;
            end
            // fence, system and anything unknown
            default:   cw.kind = k_nop;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/pc_counter.sv */
// program counter with sequential, branch and jump update
`timescale 1ns/1ps
`default_nettype none

module pc_counter (
    input  logic           clk,
    input  logic           reset,
    ctrl_if.sink           cw,
    input  rv_pkg::word_t  rs1_value,
    input  rv_pkg::flags_t flags,
    output rv_pkg::word_t  pc
);
    import rv_pkg::*;

    logic  taken;
    logic  lt_signed;
    logic  lt_unsigned;
    word_t jalr_sum;
    word_t pc_next;

    // flags come from rs1 - rs2
    assign lt_signed   = flags[flag_n] ^ flags[flag_v];
    assign lt_unsigned = ~flags[flag_c];

    always_comb begin
        case (cw.funct3)
            3'b000:  taken = flags[flag_z];
            3'b001:  taken = ~flags[flag_z];
            3'b100:  taken = lt_signed;
            3'b101:  taken = ~lt_signed;
            3'b110:  taken = lt_unsigned;
            3'b111:  taken = ~lt_unsigned;
            default: taken = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_value + cw.imm;

    always_comb begin
        case (cw.kind)
            k_jal:    pc_next = pc + cw.imm;
            k_jalr:   pc_next = {jalr_sum[31:1], 1'b0};
            k_branch: pc_next = taken ? pc + cw.imm : pc + 32'd4;
            default:  pc_next = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (cw.step) begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/datapath.sv */
// operand steering, load/store formatting, writeback and retire register
`timescale 1ns/1ps
`default_nettype none

module datapath #(
    parameter int mem_words = 128
) (
    input  logic              clk,
    input  logic              reset,
    ctrl_if.sink              cw,
    input  rv_pkg::word_t     pc,
    output rv_pkg::word_t     rs1_value,
    output rv_pkg::flags_t    flags,
    output logic              retire_we,
    output rv_pkg::reg_addr_t retire_rd,
    output rv_pkg::word_t     retire_value
);
    import rv_pkg::*;

    word_t      rs2_value;
    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_result;
    fsel_t      alu_fsel;
    word_t      mem_rdata;
    word_t      mem_wdata;
    word_t      load_data;
    word_t      wb_value;
    logic       wb_en;
    logic [3:0] byte_en;
    logic [1:0] lane;
    logic [7:0] load_byte;
    logic [15:0] load_half;

    always_comb begin
        case (cw.kind)
            k_jal, k_jalr, k_auipc: alu_a = pc;
            default:                alu_a = rs1_value;
        endcase
        case (cw.kind)
            k_reg, k_branch: alu_b = rs2_value;
            // link value is pc + 4
            k_jal, k_jalr:   alu_b = 32'd4;
            default:         alu_b = cw.imm;
        endcase
        case (cw.kind)
            k_reg:    alu_fsel = {cw.funct3, cw.funct7};
            // only srai carries the funct7 bit
            k_imm:    alu_fsel = {cw.funct3, (cw.funct3 == 3'b101) & cw.funct7};
            k_branch: alu_fsel = fs_sub;
            default:  alu_fsel = fs_add;
        endcase
    end

    function_unit funit (
        .a      (alu_a),
        .b      (alu_b),
        .fsel   (alu_fsel),
        .result (alu_result),
        .flags  (flags)
    );

    regfile regs (
        .clk      (clk),
        .reset    (reset),
        .rd_addr0 (cw.rs1),
        .rd_addr1 (cw.rs2),
        .wr_addr0 (cw.rd),
        .wr_din0  (wb_value),
        .we0      (wb_en & cw.step),
        .rd_dout0 (rs1_value),
        .rd_dout1 (rs2_value)
    );

    data_mem #(.mem_words(mem_words)) dmem (
        .clk     (clk),
        .reset   (reset),
        .addr    (alu_result),
        .wr_din  (mem_wdata),
        .we      ((cw.kind == k_store) & cw.step),
        .byte_en (byte_en),
        .rd_dout (mem_rdata)
    );

    assign lane = alu_result[1:0];

    // store lanes, data replicated across the word
    always_comb begin
        case (cw.funct3)
            3'b000: begin
                byte_en   = 4'b0001 << lane;
                mem_wdata = {4{rs2_value[7:0]}};
            end
            3'b001: begin
                byte_en   = lane[1] ? 4'b1100 : 4'b0011;
                mem_wdata = {2{rs2_value[15:0]}};
            end
            default: begin
                byte_en   = 4'b1111;
                mem_wdata = rs2_value;
            end
        endcase
    end

    // load extraction
    always_comb begin
        case (lane)
            2'd0:    load_byte = mem_rdata[7:0];
            2'd1:    load_byte = mem_rdata[15:8];
            2'd2:    load_byte = mem_rdata[23:16];
            default: load_byte = mem_rdata[31:24];
        endcase
        load_half = lane[1] ? mem_rdata[31:16] : mem_rdata[15:0];
        case (cw.funct3)
            3'b000:  load_data = {{24{load_byte[7]}}, load_byte};
            3'b001:  load_data = {{16{load_half[15]}}, load_half};
            3'b100:  load_data = {24'd0, load_byte};
            3'b101:  load_data = {16'd0, load_half};
            default: load_data = mem_rdata;
        endcase
    end

    always_comb begin
        wb_en = 1'b1;
        case (cw.kind)
            k_load:  wb_value = load_data;
            k_lui:   wb_value = cw.imm;
            k_imm, k_reg, k_auipc, k_jal, k_jalr: wb_value = alu_result;
            // store, branch and no-op write nothing
            default: begin
                wb_en    = 1'b0;
                wb_value = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_we    <= 1'b0;
            retire_rd    <= '0;
            retire_value <= '0;
        end else if (cw.step) begin
            retire_we    <= wb_en;
            retire_rd    <= wb_en ? cw.rd : '0;
            retire_value <= wb_value;
        end
    end

endmodule

`default_nettype wire

/* verilog/data_mem.sv */
// word-addressed data memory with byte write lanes
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
    parameter int mem_words = 128
) (
    input  logic          clk,
    input  logic          reset,
    input  rv_pkg::word_t addr,
    input  rv_pkg::word_t wr_din,
    input  logic          we,
    input  logic [3:0]    byte_en,
    output rv_pkg::word_t rd_dout
);
    import rv_pkg::*;

    localparam int idx_w = $clog2(mem_words);

    word_t            mem [mem_words];
    logic [idx_w-1:0] idx;

    // byte address wraps modulo mem_words words
    assign idx = addr[idx_w+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byte_en[lane]) begin
                    mem[idx][lane*8 +: 8] <= wr_din[lane*8 +: 8];
                end
            end
        end
    end

    assign rd_dout = mem[idx];

endmodule

`default_nettype wire

/* verilog/regfile.sv */
// 32 x 32 register file, two read ports, one write port, x0 tied to zero
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::reg_addr_t rd_addr0,
    input  rv_pkg::reg_addr_t rd_addr1,
    input  rv_pkg::reg_addr_t wr_addr0,
    input  rv_pkg::word_t     wr_din0,
    input  logic              we0,
    output rv_pkg::word_t     rd_dout0,
    output rv_pkg::word_t     rd_dout1
);
    import rv_pkg::*;

    word_t regs [32];

    // x0 is cleared on reset and never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we0 && wr_addr0 != '0) begin
            regs[wr_addr0] <= wr_din0;
        end
    end

    assign rd_dout0 = regs[rd_addr0];
    assign rd_dout1 = regs[rd_addr1];

endmodule

`default_nettype wire

/* verilog/function_unit.sv */
// 32-bit ALU with zero, carry, negative and overflow flags
`timescale 1ns/1ps
`default_nettype none

module function_unit (
    input  rv_pkg::word_t  a,
    input  rv_pkg::word_t  b,
    input  rv_pkg::fsel_t  fsel,
    output rv_pkg::word_t  result,
    output rv_pkg::flags_t flags
);
    import rv_pkg::*;

    logic        sub;
    logic        arith;
    word_t       b_add;
    logic [32:0] sum;
    logic        overflow;
    logic [4:0]  shamt;

    // shared adder, subtract is a + ~b + 1
    assign sub      = (fsel == fs_sub);
    assign arith    = sub | (fsel == fs_add);
    assign b_add    = sub ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, b_add} + {32'd0, sub};
    assign overflow = (a[31] == b_add[31]) && (sum[31] != a[31]);
    assign shamt    = b[4:0];

    always_comb begin
        case (fsel)
            fs_add,
            fs_sub:  result = sum[31:0];
            fs_sll:  result = a << shamt;
            fs_slt:  result = {31'd0, $signed(a) < $signed(b)};
            fs_sltu: result = {31'd0, a < b};
            fs_xor:  result = a ^ b;
            fs_srl:  result = a >> shamt;
            fs_sra:  result = $signed(a) >>> shamt;
            fs_or:   result = a | b;
            fs_and:  result = a & b;
            default: result = sum[31:0];
        endcase
    end

    // carry and overflow only mean something for add and sub
    always_comb begin
        flags         = '0;
        flags[flag_z] = (result == '0);
        flags[flag_c] = arith & sum[32];
        flags[flag_n] = result[31];
        flags[flag_v] = arith & overflow;
    end

endmodule

`default_nettype wire

/* verilog/ctrl_if.sv */
// decoded control word between the control FSM, datapath and pc counter
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;
    import rv_pkg::*;

    inst_kind_t kind;
    funct3_t    funct3;
    logic       funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      imm;
    // one-cycle commit pulse
    logic       step;

    modport ctrl (output kind, funct3, funct7, rd, rs1, rs2, imm, step);

    modport sink (input kind, funct3, funct7, rd, rs1, rs2, imm, step);

endinterface

`default_nettype wire

/* verilog/rv_pkg.sv */
// rv32i widths, instruction kind codes, function-unit selects and control states
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [3:0]  fsel_t;
    typedef logic [3:0]  flags_t;
    typedef logic [3:0]  inst_kind_t;

    // flag bit positions, z is the msb
    localparam int flag_z = 3;
    localparam int flag_c = 2;
    localparam int flag_n = 1;
    localparam int flag_v = 0;

    // instruction classes
    localparam inst_kind_t k_load   = 4'd0;
    localparam inst_kind_t k_imm    = 4'd1;
    localparam inst_kind_t k_store  = 4'd2;
    localparam inst_kind_t k_reg    = 4'd3;
    localparam inst_kind_t k_lui    = 4'd4;
    localparam inst_kind_t k_auipc  = 4'd5;
    localparam inst_kind_t k_branch = 4'd6;
    localparam inst_kind_t k_jalr   = 4'd7;
    localparam inst_kind_t k_jal    = 4'd8;
    localparam inst_kind_t k_nop    = 4'd9;

    // function-unit select is {funct3, funct7 bit}
    localparam fsel_t fs_add  = 4'b0000;
    localparam fsel_t fs_sub  = 4'b0001;
    localparam fsel_t fs_sll  = 4'b0010;
    localparam fsel_t fs_slt  = 4'b0100;
    localparam fsel_t fs_sltu = 4'b0110;
    localparam fsel_t fs_xor  = 4'b1000;
    localparam fsel_t fs_srl  = 4'b1010;
    localparam fsel_t fs_sra  = 4'b1011;
    localparam fsel_t fs_or   = 4'b1100;
    localparam fsel_t fs_and  = 4'b1110;

    typedef enum logic [1:0] {st_idle, st_exec, st_ack, st_release} ctrl_state_t;

endpackage

`default_nettype wire
